// File: Makefile
# Verilator build and run for the Wishbone bus subsystem

SRCS := $(wildcard design/*.sv design/*.svh bench/*.sv)

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
obj_dir/Vtb_wb_bus: sim.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal --top-module tb_wb_bus -f sim.f

# Pass only when the log holds the pass line
run: obj_dir/Vtb_wb_bus
	./obj_dir/Vtb_wb_bus 2>&1 | tee sim.log
	grep -q "^Simulation completed successfully$$" sim.log

clean:
	rm -rf obj_dir sim.log

// File: bench/tb_wb_bus.sv
// Random master testbench for the bus subsystem, fixed seed
// One request in flight, stb dropped for 1 to 3 cycles between requests
// RAM bytes never written are masked out of read compares
`timescale 1ns/1ps
`default_nettype none

`include "wb_bus_defines.svh"

module tb_wb_bus;

  import wb_bus_pkg::*;

  localparam int N_TRANS    = 600;
  localparam int RST_CYCLES = 4;
  // Ack must come well before this many cycles
  localparam int MAX_LAT    = 4;
  localparam int WIN_BYTES  = 4096;
  // Worst case transaction is 5 cycles, small slack for the end
  localparam int TIMEOUT_CYCLES = N_TRANS * 5 + RST_CYCLES + 10;

  logic    clk_i;
  logic    rst_i;
  wb_adr_t wbm_adr_i;
  wb_dat_t wbm_dat_i;
  wb_sel_t wbm_sel_i;
  logic    wbm_we_i;
  logic    wbm_cyc_i;
  logic    wbm_stb_i;
  wb_dat_t wbm_dat_o;
  logic    wbm_ack_o;

  // Shadow RAMs with per-byte valid flags
  wb_dat_t ram0_q   [`RAM0_DEPTH];
  wb_sel_t ram0_vld [`RAM0_DEPTH];
  wb_dat_t ram1_q   [`RAM1_DEPTH];
  wb_sel_t ram1_vld [`RAM1_DEPTH];
  // Scratch registers and write counter, reset to zero
  wb_dat_t regs_q   [3];
  wb_dat_t wr_cnt;

  integer seed;
  int     cycle_cnt;
  int     err_cnt;

  wb_soc_bus wb_soc_bus_i (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .wbm_adr_i (wbm_adr_i),
    .wbm_dat_i (wbm_dat_i),
    .wbm_sel_i (wbm_sel_i),
    .wbm_we_i  (wbm_we_i),
    .wbm_cyc_i (wbm_cyc_i),
    .wbm_stb_i (wbm_stb_i),
    .wbm_dat_o (wbm_dat_o),
    .wbm_ack_o (wbm_ack_o)
  );

  // Protocol checks inside the interconnect
  bind wb_intercon wb_bus_properties u_props (
    .clk_i    (clk_i),
    .rst_i    (rst_i),
    .cyc_i    (wbm_cyc_i),
    .stb_i    (wbm_stb_i),
    .ack_i    (wbm_ack_o),
    .s0_stb_i (wbs_0_stb_o),
    .s1_stb_i (wbs_1_stb_o),
    .s2_stb_i (wbs_2_stb_o)
  );

  // 40 ns clock
  initial begin
    clk_i = 1'b0;
    forever begin
      #20 clk_i = ~clk_i;
    end
  end

  task automatic stop_on_error(input string what);
    err_cnt++;
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1, "first error, run stopped");
  endtask

  // Hang guard
  initial begin
    cycle_cnt = 0;
    forever begin
      @(posedge clk_i);
      cycle_cnt++;
      if (cycle_cnt >= TIMEOUT_CYCLES) begin
        stop_on_error($sformatf("Timeout, run did not finish in %0d cycles", cycle_cnt));
      end
    end
  end

  function automatic int rand_below(input int n);
    return int'({$random(seed)} % n);
  endfunction

  // Byte lanes to a bit mask
  function automatic wb_dat_t lane_mask(input wb_sel_t lanes);
    wb_dat_t m;
    m = '0;
    for (int b = 0; b < `WB_SEL_W; b++) begin
      if (lanes[b]) begin
        m[b*8 +: 8] = 8'hFF;
      end
    end
    return m;
  endfunction

  // Few words per window, many aliases, so reads hit written data
  function automatic wb_adr_t pick_address(input slave_idx_t region);
    int word;
    int alias_n;
    int lsb;
    word = rand_below(8);
    lsb  = rand_below(2);
    case (region)
      RAM0: begin
        alias_n = rand_below(WIN_BYTES / (2 * `RAM0_DEPTH));
        return `RAM0_BASE + wb_adr_t'((alias_n * `RAM0_DEPTH + word) * 2 + lsb);
      end
      RAM1: begin
        alias_n = rand_below(WIN_BYTES / (2 * `RAM1_DEPTH));
        return `RAM1_BASE + wb_adr_t'((alias_n * `RAM1_DEPTH + word) * 2 + lsb);
      end
      REGS: begin
        return `REGS_BASE + wb_adr_t'((word % 4) * 2 + lsb);
      end
      default: begin
        // Anything above the register window hits nothing
        return 32'h0000_2008 + wb_adr_t'(rand_below(32'h0100_0000));
      end
    endcase
  endfunction

  task automatic write_shadow(input slave_idx_t region, input wb_adr_t adr,
                              input wb_dat_t dat, input wb_sel_t sel);
    wb_dat_t m;
    int      w;
    m = lane_mask(sel);
    case (region)
      RAM0: begin
        w = int'(adr >> 1) % `RAM0_DEPTH;
        ram0_q[w]   = (ram0_q[w] & ~m) | (dat & m);
        ram0_vld[w] = ram0_vld[w] | sel;
      end
      RAM1: begin
        w = int'(adr >> 1) % `RAM1_DEPTH;
        ram1_q[w]   = (ram1_q[w] & ~m) | (dat & m);
        ram1_vld[w] = ram1_vld[w] | sel;
      end
      REGS: begin
        w = int'(adr[2:1]);
        // Counter word is read-only and not counted
        if (w < 3) begin
          regs_q[w] = (regs_q[w] & ~m) | (dat & m);
          wr_cnt    = wr_cnt + 16'd1;
        end
      end
      default: begin
        // No target, nothing changes
      end
    endcase
  endtask

  task automatic read_shadow(input slave_idx_t region, input wb_adr_t adr,
                             output wb_dat_t exp, output wb_dat_t mask);
    int w;
    mask = '1;
    case (region)
      RAM0: begin
        w    = int'(adr >> 1) % `RAM0_DEPTH;
        exp  = ram0_q[w];
        mask = lane_mask(ram0_vld[w]);
      end
      RAM1: begin
        w    = int'(adr >> 1) % `RAM1_DEPTH;
        exp  = ram1_q[w];
        mask = lane_mask(ram1_vld[w]);
      end
      REGS: begin
        w   = int'(adr[2:1]);
        exp = (w == 3) ? wr_cnt : regs_q[w];
      end
      default: begin
        exp = '0;
      end
    endcase
  endtask

  // One request, ack check, read compare, then stb dropped
  task automatic run_transaction(input slave_idx_t region, input wb_adr_t adr,
                                 input logic we, input wb_sel_t sel, input wb_dat_t dat);
    wb_dat_t exp;
    wb_dat_t mask;
    int      waited;
    @(posedge clk_i);
    wbm_adr_i <= adr;
    wbm_dat_i <= dat;
    wbm_sel_i <= sel;
    wbm_we_i  <= we;
    wbm_cyc_i <= 1'b1;
    wbm_stb_i <= 1'b1;
    // First negedge is before the DUT samples the request
    waited = 0;
    @(negedge clk_i);
    while (!wbm_ack_o && waited < MAX_LAT) begin
      @(negedge clk_i);
      waited++;
    end
    assert (wbm_ack_o) else begin
      stop_on_error($sformatf("No acknowledge within %0d cycles for address 0x%h",
                              MAX_LAT, adr));
    end
    assert (waited == 1) else begin
      stop_on_error($sformatf("ERR wbm_ack_o latency exp=0x1 got=0x%0h adr=0x%h",
                              waited, adr));
    end
    if (we) begin
      write_shadow(region, adr, dat, sel);
    end else begin
      read_shadow(region, adr, exp, mask);
      assert ((wbm_dat_o & mask) == (exp & mask)) else begin
        stop_on_error($sformatf("ERR wbm_dat_o adr=0x%h exp=0x%h got=0x%h mask=0x%h",
                                adr, exp, wbm_dat_o, mask));
      end
    end
    @(posedge clk_i);
    wbm_stb_i <= 1'b0;
    wbm_cyc_i <= 1'b0;
    wbm_we_i  <= 1'b0;
    // Ack is a single pulse
    @(negedge clk_i);
    assert (!wbm_ack_o) else begin
      stop_on_error($sformatf("ERR wbm_ack_o exp=0x0 got=0x%h adr=0x%h", wbm_ack_o, adr));
    end
  endtask

  initial begin
    slave_idx_t region;
    wb_adr_t    adr;
    logic       we;
    wb_sel_t    sel;
    wb_dat_t    dat;
    int         pick;
    int         gap;
    seed      = 32'he4bb_f5f0;
    err_cnt   = 0;
    rst_i     = 1'b1;
    wbm_adr_i = '0;
    wbm_dat_i = '0;
    wbm_sel_i = '0;
    wbm_we_i  = 1'b0;
    wbm_cyc_i = 1'b0;
    wbm_stb_i = 1'b0;
    for (int i = 0; i < `RAM0_DEPTH; i++) begin
      ram0_q[i]   = '0;
      ram0_vld[i] = '0;
    end
    for (int i = 0; i < `RAM1_DEPTH; i++) begin
      ram1_q[i]   = '0;
      ram1_vld[i] = '0;
    end
    for (int r = 0; r < 3; r++) begin
      regs_q[r] = '0;
    end
    wr_cnt = '0;
    repeat (RST_CYCLES) @(posedge clk_i);
    rst_i <= 1'b0;
    for (int t = 0; t < N_TRANS; t++) begin
      // Weighted region pick, unmapped about one in seven
      pick = rand_below(20);
      if (pick < 6) begin
        region = RAM0;
      end else if (pick < 12) begin
        region = RAM1;
      end else if (pick < 17) begin
        region = REGS;
      end else begin
        region = MISS;
      end
      adr = pick_address(region);
      we  = (rand_below(2) == 1);
      sel = wb_sel_t'(rand_below(4));
      dat = wb_dat_t'(rand_below(65536));
      gap = 1 + rand_below(3);
      run_transaction(region, adr, we, sel, dat);
      repeat (gap - 1) @(posedge clk_i);
    end
    if (err_cnt == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/wb_bus_properties.sv
// Protocol checks bound into the interconnect
// Assumes a master that drops stb after every ack
// Checks are off while reset is high
`timescale 1ns/1ps
`default_nettype none

module wb_bus_properties (
  input wire clk_i,
  input wire rst_i,
  // Master request and combined ack
  input wire cyc_i,
  input wire stb_i,
  input wire ack_i,
  // Gated slave strobes
  input wire s0_stb_i,
  input wire s1_stb_i,
  input wire s2_stb_i
);

  // A strobed slave answers on the next edge
  strobe_acked: assert property (
    @(posedge clk_i) disable iff (rst_i)
    ((s0_stb_i || s1_stb_i || s2_stb_i) && !ack_i) |=> ack_i
  ) else $error("slave strobe not acknowledged on the next edge");

  // Ack only answers a live request
  ack_has_req: assert property (
    @(posedge clk_i) disable iff (rst_i)
    ack_i |-> (cyc_i && stb_i)
  ) else $error("acknowledge without an active request");

  // Ack is a single-cycle pulse
  ack_one_cycle: assert property (
    @(posedge clk_i) disable iff (rst_i)
    ack_i |=> !ack_i
  ) else $error("acknowledge high for two cycles in a row");

endmodule

`default_nettype wire

// File: design/wb_bus_defines.svh
// Bus widths, RAM depths and the slave address map
// Windows must not overlap; decode priority is RAM0, RAM1, REGS
// RAM depths must be powers of two and fit inside a 4 KiB window
`ifndef WB_BUS_DEFINES_SVH
`define WB_BUS_DEFINES_SVH

// Data path and byte lanes
`define WB_DAT_W 16
`define WB_SEL_W (`WB_DAT_W / 8)
`define WB_ADR_W 32

// RAM depths in words
`define RAM0_DEPTH 256
`define RAM1_DEPTH 64

// Address map, selected when (adr & mask) == base
`define RAM0_BASE 32'h0000_0000
`define RAM0_MASK 32'hFFFF_F000
`define RAM1_BASE 32'h0000_1000
`define RAM1_MASK 32'hFFFF_F000
`define REGS_BASE 32'h0000_2000
`define REGS_MASK 32'hFFFF_FFF8

`endif

// File: design/wb_bus_pkg.sv
// Shared Wishbone types for the bus subsystem
// Widths come from the defines header
`default_nettype none

`include "wb_bus_defines.svh"

package wb_bus_pkg;

  // One data word on the bus
  typedef logic [`WB_DAT_W-1:0] wb_dat_t;

  // Byte address, bit 0 ignored by every slave
  typedef logic [`WB_ADR_W-1:0] wb_adr_t;

  // Byte selects, bit 1 upper byte, bit 0 lower byte
  typedef logic [`WB_SEL_W-1:0] wb_sel_t;

  // Decoded target of a request
  typedef enum logic [1:0] {
    RAM0,
    RAM1,
    REGS,
    MISS
  } slave_idx_t;

endpackage

`default_nettype wire

// File: design/wb_intercon.sv
// Single-master shared-bus interconnect for three slaves
// Unmapped addresses get a one-cycle ack with zero read data
// Master must hold the request steady until ack and then drop stb
`timescale 1ns/1ps
`default_nettype none

`include "wb_bus_defines.svh"

module wb_intercon (
  input  wire                  clk_i,
  input  wire                  rst_i,
  // Master side
  input  wb_bus_pkg::wb_adr_t  wbm_adr_i,
  input  wb_bus_pkg::wb_dat_t  wbm_dat_i,
  input  wb_bus_pkg::wb_sel_t  wbm_sel_i,
  input  wire                  wbm_we_i,
  input  wire                  wbm_cyc_i,
  input  wire                  wbm_stb_i,
  output wb_bus_pkg::wb_dat_t  wbm_dat_o,
  output logic                 wbm_ack_o,
  // Shared slave request fields
  output wb_bus_pkg::wb_adr_t  wbs_adr_o,
  output wb_bus_pkg::wb_dat_t  wbs_dat_o,
  output wb_bus_pkg::wb_sel_t  wbs_sel_o,
  output logic                 wbs_we_o,
  output logic                 wbs_cyc_o,
  // Slave 0, RAM0
  output logic                 wbs_0_stb_o,
  input  wb_bus_pkg::wb_dat_t  wbs_0_dat_i,
  input  wire                  wbs_0_ack_i,
  // Slave 1, RAM1
  output logic                 wbs_1_stb_o,
  input  wb_bus_pkg::wb_dat_t  wbs_1_dat_i,
  input  wire                  wbs_1_ack_i,
  // Slave 2, register block
  output logic                 wbs_2_stb_o,
  input  wb_bus_pkg::wb_dat_t  wbs_2_dat_i,
  input  wire                  wbs_2_ack_i
);

  import wb_bus_pkg::*;

  slave_idx_t slave_idx;
  logic       req;
  logic       sel_ram0;
  logic       sel_ram1;
  logic       sel_regs;
  logic       sel_miss;
  logic       miss_ack_q;

  // Fixed-priority decode, map is disjoint so order only breaks ties
  always_comb begin
    if ((wbm_adr_i & `RAM0_MASK) == `RAM0_BASE) begin
      slave_idx = RAM0;
    end else if ((wbm_adr_i & `RAM1_MASK) == `RAM1_BASE) begin
      slave_idx = RAM1;
    end else if ((wbm_adr_i & `REGS_MASK) == `REGS_BASE) begin
      slave_idx = REGS;
    end else begin
      slave_idx = MISS;
    end
  end

  // One-hot selects from the decoded index
  assign sel_ram0 = (slave_idx == RAM0);
  assign sel_ram1 = (slave_idx == RAM1);
  assign sel_regs = (slave_idx == REGS);
  assign sel_miss = (slave_idx == MISS);

  // Active request from the master
  assign req = wbm_cyc_i & wbm_stb_i;

  // Request fields go to every slave unchanged
  assign wbs_adr_o = wbm_adr_i;
  assign wbs_dat_o = wbm_dat_i;
  assign wbs_sel_o = wbm_sel_i;
  assign wbs_we_o  = wbm_we_i;
  assign wbs_cyc_o = wbm_cyc_i;

  // Only the decoded slave sees a strobe
  assign wbs_0_stb_o = req & sel_ram0;
  assign wbs_1_stb_o = req & sel_ram1;
  assign wbs_2_stb_o = req & sel_regs;

  // Miss responder, same one-cycle pulse as a slave
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      miss_ack_q <= 1'b0;
    end else begin
      miss_ack_q <= req & sel_miss & ~miss_ack_q;
    end
  end

  // Combined acknowledge, at most one source is active
  assign wbm_ack_o = wbs_0_ack_i | wbs_1_ack_i | wbs_2_ack_i | miss_ack_q;

  // AND-OR read mux
  // A miss selects no slave, so the result is zero
  assign wbm_dat_o = ({`WB_DAT_W{sel_ram0}} & wbs_0_dat_i)
                   | ({`WB_DAT_W{sel_ram1}} & wbs_1_dat_i)
                   | ({`WB_DAT_W{sel_regs}} & wbs_2_dat_i);

endmodule

`default_nettype wire

// File: design/wb_ram.sv
// Single-port word RAM slave with byte-lane writes
// Contents are undefined until written; addresses alias modulo DEPTH
// DEPTH must be a power of two
`timescale 1ns/1ps
`default_nettype none

`include "wb_bus_defines.svh"

module wb_ram #(
  parameter int DEPTH = 256
) (
  input  wire                  clk_i,
  input  wire                  rst_i,
  input  wb_bus_pkg::wb_adr_t  adr_i,
  input  wb_bus_pkg::wb_dat_t  dat_i,
  input  wb_bus_pkg::wb_sel_t  sel_i,
  input  wire                  we_i,
  input  wire                  cyc_i,
  input  wire                  stb_i,
  output wb_bus_pkg::wb_dat_t  dat_o,
  output logic                 ack_o
);

  import wb_bus_pkg::*;

  localparam int IDX_W = $clog2(DEPTH);

  wb_dat_t          mem [DEPTH];
  logic [IDX_W-1:0] idx;
  logic             access;

  // Word index sits just above the ignored byte bit
  assign idx = adr_i[IDX_W:1];

  // New request, not yet acknowledged
  assign access = cyc_i & stb_i & ~ack_o;

  // Ack pulses one cycle after the strobe is first seen
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_o <= 1'b0;
    end else begin
      ack_o <= access;
    end
  end

  // Storage and read data, updated on the ack edge
  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_o <= mem[idx];
      if (we_i) begin
        for (int b = 0; b < `WB_SEL_W; b++) begin
          if (sel_i[b]) begin
            mem[idx][b*8 +: 8] <= dat_i[b*8 +: 8];
          end
        end
      end
    end
  end

endmodule

`default_nettype wire

// File: design/wb_regfile.sv
// Register slave with three scratch words and a write counter
// Word 3 is read-only and counts writes to words 0 to 2
// Only address bits 2:1 are decoded
`timescale 1ns/1ps
`default_nettype none

`include "wb_bus_defines.svh"

module wb_regfile (
  input  wire                  clk_i,
  input  wire                  rst_i,
  input  wb_bus_pkg::wb_adr_t  adr_i,
  input  wb_bus_pkg::wb_dat_t  dat_i,
  input  wb_bus_pkg::wb_sel_t  sel_i,
  input  wire                  we_i,
  input  wire                  cyc_i,
  input  wire                  stb_i,
  output wb_bus_pkg::wb_dat_t  dat_o,
  output logic                 ack_o
);

  import wb_bus_pkg::*;

  localparam logic [1:0] CNT_WORD = 2'd3;

  wb_dat_t    scratch_q [3];
  wb_dat_t    wr_cnt_q;
  wb_dat_t    rd_word;
  logic [1:0] word;
  logic       access;
  logic       scratch_wr;

  assign word       = adr_i[2:1];
  assign access     = cyc_i & stb_i & ~ack_o;
  // Writes to the counter word are dropped
  assign scratch_wr = access & we_i & (word != CNT_WORD);

  // Ack, scratch words and counter
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_o    <= 1'b0;
      wr_cnt_q <= '0;
      for (int r = 0; r < 3; r++) begin
        scratch_q[r] <= '0;
      end
    end else begin
      ack_o <= access;
      if (scratch_wr) begin
        for (int b = 0; b < `WB_SEL_W; b++) begin
          if (sel_i[b]) begin
            scratch_q[word][b*8 +: 8] <= dat_i[b*8 +: 8];
          end
        end
        // Wraps naturally at the word width
        wr_cnt_q <= wr_cnt_q + 1'b1;
      end
    end
  end

  // Read select
  assign rd_word = (word == CNT_WORD) ? wr_cnt_q : scratch_q[word];

  // Read data registered with ack
  always_ff @(posedge clk_i) begin
    if (access) begin
      dat_o <= rd_word;
    end
  end

endmodule

`default_nettype wire

// File: design/wb_soc_bus.sv
// Top level of the bus subsystem, one external master port
// Every transaction acks exactly one cycle after its first strobe
`timescale 1ns/1ps
`default_nettype none

`include "wb_bus_defines.svh"

module wb_soc_bus (
  input  wire                  clk_i,
  input  wire                  rst_i,
  input  wb_bus_pkg::wb_adr_t  wbm_adr_i,
  input  wb_bus_pkg::wb_dat_t  wbm_dat_i,
  input  wb_bus_pkg::wb_sel_t  wbm_sel_i,
  input  wire                  wbm_we_i,
  input  wire                  wbm_cyc_i,
  input  wire                  wbm_stb_i,
  output wb_bus_pkg::wb_dat_t  wbm_dat_o,
  output logic                 wbm_ack_o
);

  import wb_bus_pkg::*;

  // Shared request fields
  wb_adr_t wbs_adr;
  wb_dat_t wbs_dat;
  wb_sel_t wbs_sel;
  logic    wbs_we;
  logic    wbs_cyc;

  // Per-slave strobe, read data and ack
  logic    s0_stb, s1_stb, s2_stb;
  wb_dat_t s0_dat, s1_dat, s2_dat;
  logic    s0_ack, s1_ack, s2_ack;

  wb_intercon u_intercon (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .wbm_adr_i   (wbm_adr_i),
    .wbm_dat_i   (wbm_dat_i),
    .wbm_sel_i   (wbm_sel_i),
    .wbm_we_i    (wbm_we_i),
    .wbm_cyc_i   (wbm_cyc_i),
    .wbm_stb_i   (wbm_stb_i),
    .wbm_dat_o   (wbm_dat_o),
    .wbm_ack_o   (wbm_ack_o),
    .wbs_adr_o   (wbs_adr),
    .wbs_dat_o   (wbs_dat),
    .wbs_sel_o   (wbs_sel),
    .wbs_we_o    (wbs_we),
    .wbs_cyc_o   (wbs_cyc),
    .wbs_0_stb_o (s0_stb),
    .wbs_0_dat_i (s0_dat),
    .wbs_0_ack_i (s0_ack),
    .wbs_1_stb_o (s1_stb),
    .wbs_1_dat_i (s1_dat),
    .wbs_1_ack_i (s1_ack),
    .wbs_2_stb_o (s2_stb),
    .wbs_2_dat_i (s2_dat),
    .wbs_2_ack_i (s2_ack)
  );

  // 4 KiB window at 0x0000
  wb_ram #(.DEPTH(`RAM0_DEPTH)) u_ram0 (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .adr_i (wbs_adr),
    .dat_i (wbs_dat),
    .sel_i (wbs_sel),
    .we_i  (wbs_we),
    .cyc_i (wbs_cyc),
    .stb_i (s0_stb),
    .dat_o (s0_dat),
    .ack_o (s0_ack)
  );

  // 4 KiB window at 0x1000
  wb_ram #(.DEPTH(`RAM1_DEPTH)) u_ram1 (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .adr_i (wbs_adr),
    .dat_i (wbs_dat),
    .sel_i (wbs_sel),
    .we_i  (wbs_we),
    .cyc_i (wbs_cyc),
    .stb_i (s1_stb),
    .dat_o (s1_dat),
    .ack_o (s1_ack)
  );

  // Four words at 0x2000
  wb_regfile u_regs (
    .clk_i (clk_i),
    .rst_i (rst_i),
    .adr_i (wbs_adr),
    .dat_i (wbs_dat),
    .sel_i (wbs_sel),
    .we_i  (wbs_we),
    .cyc_i (wbs_cyc),
    .stb_i (s2_stb),
    .dat_o (s2_dat),
    .ack_o (s2_ack)
  );

endmodule

`default_nettype wire

// File: sim.f
+incdir+design
design/wb_bus_pkg.sv
design/wb_intercon.sv
design/wb_ram.sv
design/wb_regfile.sv
design/wb_soc_bus.sv
bench/wb_bus_properties.sv
bench/tb_wb_bus.sv
